// ==== src.f ====
logic/videoTxPkg.sv
logic/videoTxCsr.sv
logic/videoTiming.sv
logic/videoTxTop.sv
dv/videoTxTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the video transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module videoTxTb -f src.f -o videoTxSim
./obj_dir/videoTxSim | tee sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"

// ==== dv/videoTxTb.sv ====
/*
 * Video transmitter testbench
 * APB register checks plus line, frame and idle timing checks on the sync outputs
 */
`timescale 1ns/1ps

module videoTxTb;
	import videoTxPkg::*;

	localparam timingCfgT cfgSmall = '{hDisplay: 12'd16, hFront: 8'd2, hPulse: 8'd3,
		hBack: 8'd4, vDisplay: 11'd8, vFront: 8'd1, vPulse: 8'd2, vBack: 8'd2};
	localparam timingCfgT cfgLarge = '{hDisplay: 12'd20, hFront: 8'd3, hPulse: 8'd4,
		hBack: 8'd5, vDisplay: 11'd10, vFront: 8'd2, vPulse: 8'd3, vBack: 8'd2};
	localparam int largeFrame = (20 + 3 + 4 + 5) * (10 + 2 + 3 + 2);
	localparam int maxCycles  = 20 * largeFrame + 2000;

	logic iSysClk = 1'b0;
	logic reset;
	apbReqT apb;
	apbRspT apbRsp;
	logic hSync, vSync, de;
	hCountT pixelX, prevX;
	vCountT pixelY, prevY;

	logic [15:0] lfsr;
	string testName;
	int busErrors, videoErrors, cycles;
	logic rdChk, errChk, errExp, mon, quiet, vrstOn, gapOk, frameStart;
	apbDataT rdExp;
	timingCfgT pend, act;				// Registers as written and timing of the current frame
	logic hSyncQ, vSyncQ, deQ;
	int hRun, deRun, vRun, hGap, deLines, vRises;
	logic [31:0] expHTotal, expVSyncCycles;

	videoTxTop #(
		.pHDisplay(cfgSmall.hDisplay), .pHFront(cfgSmall.hFront), .pHPulse(cfgSmall.hPulse),
		.pHBack(cfgSmall.hBack), .pVDisplay(cfgSmall.vDisplay), .pVFront(cfgSmall.vFront),
		.pVPulse(cfgSmall.vPulse), .pVBack(cfgSmall.vBack)
	) UUT (
		.iSysClk(iSysClk), .reset(reset), .apb(apb), .apbRsp(apbRsp),
		.hSync(hSync), .vSync(vSync), .de(de), .pixelX(pixelX), .pixelY(pixelY)
	);

	always #10 iSysClk = ~iSysClk;

	assign expHTotal      = 32'(act.hDisplay) + 32'(act.hFront) + 32'(act.hPulse) + 32'(act.hBack);
	assign expVSyncCycles = 32'(act.vPulse) * expHTotal;
	assign frameStart     = (pixelX == 0) && (pixelY == 0) && ((prevX != 0) || (prevY != 0));

	function automatic apbDataT randWord();
		apbDataT w;
		w = '0;
		for (int i = 0; i < 32; i++)
		begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			w    = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic apbDataT regMask(input apbAddrT addr);
		case (addr)
			regHTiming: return 32'h0000_0FFF;
			regHPorch, regVPorch: return 32'h00FF_FFFF;
			regVTiming: return 32'h0000_07FF;
			regControl: return 32'h0000_0003;
			default: return 32'h0;
		endcase
	endfunction

	// Expected sync point words from the written timing
	function automatic apbDataT syncWord(input timingCfgT c, input apbAddrT addr);
		hCountT hs, he, hm;
		vCountT vs, ve, vm;
		hs = c.hDisplay + hCountT'(c.hFront);
		he = hs + hCountT'(c.hPulse) - hCountT'(1);
		hm = he + hCountT'(c.hBack);
		vs = c.vDisplay + vCountT'(c.vFront);
		ve = vs + vCountT'(c.vPulse) - vCountT'(1);
		vm = ve + vCountT'(c.vBack);
		if (addr == regHSync)
			return {4'd0, he, 4'd0, hs};
		else if (addr == regVSync)
			return {5'd0, ve, 5'd0, vs};
		return {5'd0, vm, 4'd0, hm};
	endfunction

	task automatic reportValue(input bit isBus, input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (isBus)
			busErrors++;
		else
			videoErrors++;
		$display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, got);
	endtask

	//----------------------------------------------------------------------
	// APB driver
	//----------------------------------------------------------------------
	task automatic apbWrite(input apbAddrT addr, input apbDataT data);
		logic err;
		err = !(addr inside {regHTiming, regHPorch, regVTiming, regVPorch, regControl});
		@(posedge iSysClk);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge iSysClk);
		apb.penable <= 1'b1;
		errExp      <= err;
		errChk      <= 1'b1;
		@(posedge iSysClk);
		apb    <= '0;
		errChk <= 1'b0;
		case (addr)				// Model of the register contents
			regHTiming: pend.hDisplay <= data[11:0];
			regHPorch:  {pend.hBack, pend.hPulse, pend.hFront} <= data[23:0];
			regVTiming: pend.vDisplay <= data[10:0];
			regVPorch:  {pend.vBack, pend.vPulse, pend.vFront} <= data[23:0];
			regControl: vrstOn <= data[0];
			default: ;
		endcase
	endtask

	task automatic apbRead(input apbAddrT addr, input apbDataT exp, input logic err);
		@(posedge iSysClk);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(posedge iSysClk);
		apb.penable <= 1'b1;
		rdExp       <= exp;
		rdChk       <= 1'b1;
		errExp      <= err;
		errChk      <= 1'b1;
		@(posedge iSysClk);
		apb    <= '0;
		rdChk  <= 1'b0;
		errChk <= 1'b0;
	endtask

	task automatic setTiming(input timingCfgT c);
		apbWrite(regHTiming, {20'd0, c.hDisplay});
		apbWrite(regHPorch, {8'd0, c.hBack, c.hPulse, c.hFront});
		apbWrite(regVTiming, {21'd0, c.vDisplay});
		apbWrite(regVPorch, {8'd0, c.vBack, c.vPulse, c.vFront});
	endtask

	task automatic waitFrames(input int n);
		int target;
		target = vRises + n;
		while (vRises < target)
			@(posedge iSysClk);
	endtask

	//----------------------------------------------------------------------
	// Output monitors
	//----------------------------------------------------------------------
	always @(posedge iSysClk)
	begin
		hSyncQ <= hSync;
		vSyncQ <= vSync;
		deQ    <= de;
		prevX  <= pixelX;
		prevY  <= pixelY;
		if (vrstOn || frameStart)
			act <= pend;					// Generator reloads its shadow here
		if (!mon)
		begin
			hRun    <= 0;
			deRun   <= 0;
			vRun    <= 0;
			hGap    <= 0;
			gapOk   <= 1'b0;
			deLines <= 0;
		end
		else
		begin
			hRun  <= hSync ? hRun + 1 : 0;
			deRun <= de ? deRun + 1 : 0;
			vRun  <= vSync ? vRun + 1 : 0;
			if (hSync && !hSyncQ)
			begin
				hGap  <= 1;
				gapOk <= 1'b1;
			end
			else
			begin
				hGap <= hGap + 1;
				if (frameStart)
					gapOk <= 1'b0;		// Line length may change here
			end
			if (vSync && !vSyncQ)
			begin
				vRises  <= vRises + 1;
				deLines <= 0;
			end
			else if (de && !deQ)
				deLines <= deLines + 1;
		end
	end

	apbReady: assert property (@(posedge iSysClk) disable iff (reset)
		(apb.psel && apb.penable) |-> apbRsp.pready)
		else reportValue(1, {testName, " / pready"}, 1, $sampled(apbRsp.pready));
	readData: assert property (@(posedge iSysClk) disable iff (reset)
		rdChk |-> (apbRsp.prdata == rdExp))
		else reportValue(1, {testName, " / prdata"}, $sampled(rdExp), $sampled(apbRsp.prdata));
	slaveError: assert property (@(posedge iSysClk) disable iff (reset)
		errChk |-> (apbRsp.pslverr == errExp))
		else reportValue(1, {testName, " / pslverr"}, $sampled(errExp), $sampled(apbRsp.pslverr));
	hSyncWidth: assert property (@(posedge iSysClk) disable iff (reset)
		(mon && $fell(hSync)) |-> (hRun == act.hPulse))
		else reportValue(0, {testName, " / hSync width"}, $sampled(act.hPulse), $sampled(hRun));
	hSyncPeriod: assert property (@(posedge iSysClk) disable iff (reset)
		(mon && gapOk && $rose(hSync)) |-> (hGap == expHTotal))
		else reportValue(0, {testName, " / hSync period"}, $sampled(expHTotal), $sampled(hGap));
	hSyncPosition: assert property (@(posedge iSysClk) disable iff (reset)
		(mon && $rose(hSync)) |-> (pixelX == act.hDisplay + act.hFront))
		else reportValue(0, {testName, " / pixelX at hSync"},
			$sampled(act.hDisplay + act.hFront), $sampled(pixelX));
	deWidth: assert property (@(posedge iSysClk) disable iff (reset)
		(mon && $fell(de)) |-> (deRun == act.hDisplay))
		else reportValue(0, {testName, " / de width"}, $sampled(act.hDisplay), $sampled(deRun));
	vSyncWidth: assert property (@(posedge iSysClk) disable iff (reset)
		(mon && $fell(vSync)) |-> (vRun == expVSyncCycles))
		else reportValue(0, {testName, " / vSync cycles"}, $sampled(expVSyncCycles),
			$sampled(vRun));
	vSyncPosition: assert property (@(posedge iSysClk) disable iff (reset)
		(mon && $rose(vSync)) |-> (pixelY == act.vDisplay + act.vFront))
		else reportValue(0, {testName, " / pixelY at vSync"},
			$sampled(act.vDisplay + act.vFront), $sampled(pixelY));
	deLineCount: assert property (@(posedge iSysClk) disable iff (reset)
		(mon && $rose(vSync)) |-> (deLines == act.vDisplay))
		else reportValue(0, {testName, " / de lines"}, $sampled(act.vDisplay), $sampled(deLines));
	idleQuiet: assert property (@(posedge iSysClk) disable iff (reset)
		quiet |-> ({hSync, vSync, de} == 3'b000))
		else reportValue(0, {testName, " / idle outputs"}, 0, $sampled({hSync, vSync, de}));

	always @(posedge iSysClk)
	begin
		cycles <= cycles + 1;
		if (cycles >= maxCycles)
		begin
			$display("Timeout: run did not finish within %0d cycles", maxCycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial
	begin
		apbDataT d;
		reset <= 1'b1;
		apb <= '0;
		{rdChk, errChk, errExp, mon} <= 4'b0000;
		rdExp <= '0;
		quiet <= 1'b1;						// Video in reset after power up
		vrstOn <= 1'b1;
		pend <= cfgSmall;
		act <= cfgSmall;
		lfsr = 16'd31524;
		busErrors = 0;
		videoErrors = 0;
		repeat (10) @(posedge iSysClk);
		reset <= 1'b0;

		testName = "reset defaults";
		apbRead(regHTiming, {20'd0, cfgSmall.hDisplay}, 1'b0);
		apbRead(regHPorch, {8'd0, cfgSmall.hBack, cfgSmall.hPulse, cfgSmall.hFront}, 1'b0);
		apbRead(regVTiming, {21'd0, cfgSmall.vDisplay}, 1'b0);
		apbRead(regVPorch, {8'd0, cfgSmall.vBack, cfgSmall.vPulse, cfgSmall.vFront}, 1'b0);
		apbRead(regControl, 32'h1, 1'b0);
		apbRead(regFrames, 32'd0, 1'b0);

		testName = "readback";
		for (int a = 0; a < 5; a++)
		begin
			d = randWord();
			if (a == 0 && d[11:0] == 12'd0)
				d[0] = 1'b1;				// Zero width line is illegal
			if (a == 4)
				d[0] = 1'b1;				// Keep video in reset
			apbWrite(apbAddrT'(a * 4), d);
			apbRead(apbAddrT'(a * 4), d & regMask(apbAddrT'(a * 4)), 1'b0);
		end

		testName = "derived points";
		apbRead(regHSync, syncWord(pend, regHSync), 1'b0);
		apbRead(regVSync, syncWord(pend, regVSync), 1'b0);
		apbRead(regMax, syncWord(pend, regMax), 1'b0);
		apbWrite(regHSync, randWord());		// Read only register keeps its value
		apbRead(regHSync, syncWord(pend, regHSync), 1'b0);

		testName = "unmapped";
		apbRead(12'h040, 32'd0, 1'b1);
		apbWrite(12'h040, randWord());
		apbRead(12'h090, 32'd0, 1'b1);

		testName = "line timing";
		setTiming(cfgSmall);
		mon <= 1'b1;
		quiet <= 1'b0;
		apbWrite(regControl, 32'h2);
		waitFrames(2);

		testName = "frame timing";
		while (!(pixelX == 0 && pixelY == 2))
			@(posedge iSysClk);
		setTiming(cfgLarge);				// Applies from the next frame
		waitFrames(3);
		while (!(pixelX == 5 && pixelY == 0))
			@(posedge iSysClk);
		mon <= 1'b0;

		testName = "idle control";
		apbWrite(regControl, 32'h0);
		repeat (2) @(posedge iSysClk);
		quiet <= 1'b1;
		apbRead(regFrames, {16'd0, vRises[15:0]}, 1'b0);
		repeat (40) @(posedge iSysClk);
		apbWrite(regControl, 32'h3);		// Enabled but held in video reset
		repeat (40) @(posedge iSysClk);

		$display("Errors: bus %0d, video %0d", busErrors, videoErrors);
		if (busErrors == 0 && videoErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== logic/videoTxTop.sv ====
/*
 * LCD video transmitter top level
 * APB register block beside the sync generator, both on iSysClk
 */
`timescale 1ns/1ps

module videoTxTop #(
	parameter videoTxPkg::hCountT pHDisplay = 12'd480,
	parameter videoTxPkg::porchT  pHFront   = 8'd8,
	parameter videoTxPkg::porchT  pHPulse   = 8'd30,
	parameter videoTxPkg::porchT  pHBack    = 8'd43,
	parameter videoTxPkg::vCountT pVDisplay = 11'd272,
	parameter videoTxPkg::porchT  pVFront   = 8'd12,
	parameter videoTxPkg::porchT  pVPulse   = 8'd10,
	parameter videoTxPkg::porchT  pVBack    = 8'd4
)(
	input  logic               iSysClk,
	input  logic               reset,
	input  videoTxPkg::apbReqT apb,
	output videoTxPkg::apbRspT apbRsp,
	output logic               hSync,
	output logic               vSync,
	output logic               de,
	output videoTxPkg::hCountT pixelX,
	output videoTxPkg::vCountT pixelY
);
	import videoTxPkg::*;

	timingCfgT  timingCfg;
	syncPointsT syncPoints;
	logic       videoRst;
	logic       enable;
	logic       frameEnd;

	//----------------------------------------------------------------------
	// Register block and sync generator
	//----------------------------------------------------------------------
	videoTxCsr #(
		.pHDisplay(pHDisplay), .pHFront(pHFront), .pHPulse(pHPulse), .pHBack(pHBack),
		.pVDisplay(pVDisplay), .pVFront(pVFront), .pVPulse(pVPulse), .pVBack(pVBack)
	) csr (
		.iSysClk(iSysClk), .reset(reset),
		.apb(apb), .apbRsp(apbRsp),
		.frameEnd(frameEnd),				// Counted for regFrames
		.timing(timingCfg), .sync(syncPoints),
		.videoRst(videoRst), .enable(enable)
	);

	videoTiming timing (
		.iSysClk(iSysClk), .reset(reset),
		.timing(timingCfg), .sync(syncPoints),
		.videoRst(videoRst), .enable(enable),
		.hSync(hSync), .vSync(vSync), .de(de),
		.pixelX(pixelX), .pixelY(pixelY),
		.frameEnd(frameEnd)
	);

endmodule

// ==== logic/videoTiming.sv ====
/*
 * Video sync generator
 * Pixel and line counters producing hSync, vSync, de and coordinates per frame
 */
`timescale 1ns/1ps

module videoTiming (
	input  logic                   iSysClk,
	input  logic                   reset,
	input  videoTxPkg::timingCfgT  timing,
	input  videoTxPkg::syncPointsT sync,
	input  logic                   videoRst,
	input  logic                   enable,
	output logic                   hSync,
	output logic                   vSync,
	output logic                   de,
	output videoTxPkg::hCountT     pixelX,
	output videoTxPkg::vCountT     pixelY,
	output logic                   frameEnd
);
	import videoTxPkg::*;

	timingCfgT  shTiming;		// Timing in use for the current frame
	syncPointsT shSync;
	hCountT     hCount;
	vCountT     vCount;
	logic       run;
	logic       lineEnd;
	logic       lastPixel;

	assign run       = !videoRst && enable;
	assign lineEnd   = hCount == shSync.hMax;
	assign lastPixel = run && lineEnd && (vCount == shSync.vMax);

	//----------------------------------------------------------------------
	// Shadow copy, swapped only between frames
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset || videoRst || lastPixel)
		begin
			shTiming <= timing;
			shSync   <= sync;
		end
	end

	//----------------------------------------------------------------------
	// Position counters
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset || !run)
		begin
			hCount <= '0;				// Parked at origin while idle
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			if (vCount == shSync.vMax)
				vCount <= '0;
			else
				vCount <= vCount + vCountT'(1);
		end
		else
		begin
			hCount <= hCount + hCountT'(1);
		end
	end

	// Registered strobes, one cycle behind the counters
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			hSync    <= 1'b0;
			vSync    <= 1'b0;
			de       <= 1'b0;
			pixelX   <= '0;
			pixelY   <= '0;
			frameEnd <= 1'b0;
		end
		else
		begin
			hSync    <= run && (hCount >= shSync.hSyncStart) && (hCount <= shSync.hSyncEnd);
			vSync    <= run && (vCount >= shSync.vSyncStart) && (vCount <= shSync.vSyncEnd);
			de       <= run && (hCount < shTiming.hDisplay) && (vCount < shTiming.vDisplay);
			pixelX   <= hCount;
			pixelY   <= vCount;
			frameEnd <= lastPixel;		// Single pulse per frame
		end
	end

	//----------------------------------------------------------------------
	// Output sanity
	//----------------------------------------------------------------------
	hSyncNotInDisplay: assert property (@(posedge iSysClk) disable iff (reset)
		!(hSync && de))
		else $error("hSync overlaps active video");

	vSyncNotInDisplay: assert property (@(posedge iSysClk) disable iff (reset)
		!(vSync && de))
		else $error("vSync overlaps active video");

	// pixelX lags the counter, so it is bounded by last cycle's shadow
	pixelXInLine: assert property (@(posedge iSysClk) disable iff (reset)
		pixelX <= $past(shSync.hMax))
		else $error("pixelX beyond line end");

endmodule

// ==== logic/videoTxCsr.sv ====
/*
 * Video transmitter control/status registers
 * APB slave holding panel timing, control bits, derived sync points and frame count
 */
`timescale 1ns/1ps

module videoTxCsr #(
	parameter videoTxPkg::hCountT pHDisplay = 12'd480,
	parameter videoTxPkg::porchT  pHFront   = 8'd8,
	parameter videoTxPkg::porchT  pHPulse   = 8'd30,
	parameter videoTxPkg::porchT  pHBack    = 8'd43,
	parameter videoTxPkg::vCountT pVDisplay = 11'd272,
	parameter videoTxPkg::porchT  pVFront   = 8'd12,
	parameter videoTxPkg::porchT  pVPulse   = 8'd10,
	parameter videoTxPkg::porchT  pVBack    = 8'd4
)(
	input  logic                   iSysClk,
	input  logic                   reset,
	input  videoTxPkg::apbReqT     apb,
	output videoTxPkg::apbRspT     apbRsp,
	input  logic                   frameEnd,
	output videoTxPkg::timingCfgT  timing,
	output videoTxPkg::syncPointsT sync,
	output logic                   videoRst,
	output logic                   enable
);
	import videoTxPkg::*;

	apbStateT   state;
	logic       setup;			// Setup phase seen this cycle
	logic       wrEn;
	logic       addrHit;
	logic       roHit;
	apbDataT    rdData;
	apbDataT    prdataQ;
	logic       pslverrQ;
	timingCfgT  cfg;
	syncPointsT syncQ;
	frameCountT frameCount;

	assign setup = apb.psel && !apb.penable;
	assign wrEn  = (state == apbAccess) && apb.psel && apb.penable && apb.pwrite;

	//----------------------------------------------------------------------
	// APB phase tracking and response
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			state    <= apbIdle;
			prdataQ  <= '0;
			pslverrQ <= 1'b0;
		end
		else
		begin
			state    <= setup ? apbAccess : apbIdle;
			prdataQ  <= (setup && !apb.pwrite) ? rdData : '0;	// Valid in access cycle
			pslverrQ <= setup && (!addrHit || (apb.pwrite && roHit));
		end
	end

	assign apbRsp = '{prdata: prdataQ, pready: (state == apbAccess), pslverr: pslverrQ};

	// Read mux and address decode
	always_comb
	begin
		rdData  = '0;
		addrHit = 1'b1;
		roHit   = 1'b0;
		case (apb.paddr)
			regHTiming: rdData = {20'd0, cfg.hDisplay};
			regHPorch:  rdData = {8'd0, cfg.hBack, cfg.hPulse, cfg.hFront};
			regVTiming: rdData = {21'd0, cfg.vDisplay};
			regVPorch:  rdData = {8'd0, cfg.vBack, cfg.vPulse, cfg.vFront};
			regControl: rdData = {30'd0, enable, videoRst};
			regHSync:
			begin
				rdData = {4'd0, syncQ.hSyncEnd, 4'd0, syncQ.hSyncStart};
				roHit  = 1'b1;
			end
			regVSync:
			begin
				rdData = {5'd0, syncQ.vSyncEnd, 5'd0, syncQ.vSyncStart};
				roHit  = 1'b1;
			end
			regMax:
			begin
				rdData = {5'd0, syncQ.vMax, 4'd0, syncQ.hMax};
				roHit  = 1'b1;
			end
			regFrames:
			begin
				rdData = {16'd0, frameCount};
				roHit  = 1'b1;
			end
			default: addrHit = 1'b0;	// Reads zero with pslverr
		endcase
	end

	//----------------------------------------------------------------------
	// Timing and control registers
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			cfg      <= '{hDisplay: pHDisplay, hFront: pHFront, hPulse: pHPulse,
				hBack: pHBack, vDisplay: pVDisplay, vFront: pVFront,
				vPulse: pVPulse, vBack: pVBack};
			videoRst <= 1'b1;			// Video held in reset until released
			enable   <= 1'b0;
		end
		else if (wrEn)
		begin
			case (apb.paddr)
				regHTiming: cfg.hDisplay <= apb.pwdata[11:0];
				regHPorch:  {cfg.hBack, cfg.hPulse, cfg.hFront} <= apb.pwdata[23:0];
				regVTiming: cfg.vDisplay <= apb.pwdata[10:0];
				regVPorch:  {cfg.vBack, cfg.vPulse, cfg.vFront} <= apb.pwdata[23:0];
				regControl:
				begin
					videoRst <= apb.pwdata[0];
					enable   <= apb.pwdata[1];
				end
				default: ;					// Read only or unmapped
			endcase
		end
	end

	// Derived sync points, one cycle behind the registers
	always_ff @(posedge iSysClk)
	begin
		syncQ.hSyncStart <= cfg.hDisplay + hCountT'(cfg.hFront);
		syncQ.hSyncEnd   <= cfg.hDisplay + hCountT'(cfg.hFront) + hCountT'(cfg.hPulse)
			- hCountT'(1);
		syncQ.hMax       <= cfg.hDisplay + hCountT'(cfg.hFront) + hCountT'(cfg.hPulse)
			+ hCountT'(cfg.hBack) - hCountT'(1);
		syncQ.vSyncStart <= cfg.vDisplay + vCountT'(cfg.vFront);
		syncQ.vSyncEnd   <= cfg.vDisplay + vCountT'(cfg.vFront) + vCountT'(cfg.vPulse)
			- vCountT'(1);
		syncQ.vMax       <= cfg.vDisplay + vCountT'(cfg.vFront) + vCountT'(cfg.vPulse)
			+ vCountT'(cfg.vBack) - vCountT'(1);
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			frameCount <= '0;
		else if (frameEnd)
			frameCount <= frameCount + frameCountT'(1);
	end

	assign timing = cfg;
	assign sync   = syncQ;

	//----------------------------------------------------------------------
	// Bus protocol checks
	//----------------------------------------------------------------------
	apbEnableAfterSel: assert property (@(posedge iSysClk) disable iff (reset)
		$rose(apb.penable) |-> $past(apb.psel))
		else $error("penable rose without psel in the previous cycle");

	apbErrWithReady: assert property (@(posedge iSysClk) disable iff (reset)
		apbRsp.pslverr |-> (apbRsp.pready && apb.psel && apb.penable))
		else $error("pslverr driven outside the access cycle");

	hDisplayNonZero: assert property (@(posedge iSysClk) disable iff (reset)
		(wrEn && apb.paddr == regHTiming) |-> (apb.pwdata[11:0] != 12'd0))
		else $error("hDisplay written as zero");

endmodule

// ==== logic/videoTxPkg.sv ====
/*
 * Video transmitter shared types
 * Width typedefs, timing and sync-point structs, APB structs and register map
 */
package videoTxPkg;

	//----------------------------------------------------------------------
	// Widths with a meaning
	//----------------------------------------------------------------------
	typedef logic [11:0] hCountT;		// Horizontal count, totals up to 4095
	typedef logic [10:0] vCountT;		// Vertical line count
	typedef logic [7:0]  porchT;		// Porch and pulse widths
	typedef logic [11:0] apbAddrT;		// APB byte address
	typedef logic [31:0] apbDataT;
	typedef logic [15:0] frameCountT;

	// Panel timing as held by the register block
	typedef struct packed {
		hCountT hDisplay;
		porchT  hFront;
		porchT  hPulse;
		porchT  hBack;
		vCountT vDisplay;
		porchT  vFront;
		porchT  vPulse;
		porchT  vBack;
	} timingCfgT;

	// Derived sync points, all inclusive positions
	typedef struct packed {
		hCountT hSyncStart;		// display + front
		hCountT hSyncEnd;		// display + front + pulse - 1
		hCountT hMax;			// Last pixel of a line
		vCountT vSyncStart;
		vCountT vSyncEnd;
		vCountT vMax;			// Last line of a frame
	} syncPointsT;

	typedef struct packed {
		logic    psel;
		logic    penable;
		logic    pwrite;
		apbAddrT paddr;
		apbDataT pwdata;
	} apbReqT;

	typedef struct packed {
		apbDataT prdata;
		logic    pready;
		logic    pslverr;
	} apbRspT;

	//----------------------------------------------------------------------
	// Register offsets
	//----------------------------------------------------------------------
	localparam apbAddrT regHTiming = 12'h000;
	localparam apbAddrT regHPorch  = 12'h004;
	localparam apbAddrT regVTiming = 12'h008;
	localparam apbAddrT regVPorch  = 12'h00C;
	localparam apbAddrT regControl = 12'h010;
	localparam apbAddrT regHSync   = 12'h080;	// Read only from here on
	localparam apbAddrT regVSync   = 12'h084;
	localparam apbAddrT regMax     = 12'h088;
	localparam apbAddrT regFrames  = 12'h08C;

	typedef enum logic {
		apbIdle,
		apbAccess
	} apbStateT;

endpackage
